/* Bender.yml */
package:
  name: gpr_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/gpr_types_pkg.sv
      - src/gpr_msg_pkg.sv
      - src/gpr_req_xbar.sv
      - src/gpr_bank.sv
      - src/gpr_rsp_route.sv
      - src/gpr_unit.sv

  - target: test
    include_dirs:
      - src
    files:
      - test/gpr_unit_tb.sv

/* filelist.f */
+incdir+src
src/gpr_types_pkg.sv
src/gpr_msg_pkg.sv
src/gpr_req_xbar.sv
src/gpr_bank.sv
src/gpr_rsp_route.sv
src/gpr_unit.sv
test/gpr_unit_tb.sv

/* src/gpr_bank.sv */
`timescale 1ns/100ps
`include "gpr_defines.svh"

/* one register bank holding all lanes of a warp register per row
   lane-masked writes, a registered read-first read port and the matching response tag */
module gpr_bank (
    input logic clk,
    input logic reset,

    input logic rd_valid,
    input gpr_msg_pkg::bank_req_t rd_req,

    input logic wr_en,
    input gpr_types_pkg::bank_addr_t wr_addr,
    input gpr_types_pkg::lane_mask_t wr_mask,
    input gpr_types_pkg::lane_data_t wr_data,

    output logic rsp_valid,
    output gpr_msg_pkg::bank_rsp_t rsp
);

    localparam int ROWS = `GPR_NUM_WARPS * `GPR_NUM_REGS / `GPR_NUM_BANKS;
    localparam int XLEN = `GPR_XLEN;

    gpr_types_pkg::lane_data_t mem [ROWS];
    gpr_types_pkg::lane_data_t rd_data;
    gpr_types_pkg::req_idx_t tag_idx;
    gpr_types_pkg::opd_id_t tag_opd;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int l = 0; l < `GPR_LANES; l++) begin
                if (wr_mask[l]) begin
                    mem[wr_addr][l*XLEN +: XLEN] <= wr_data[l*XLEN +: XLEN];
                end
            end
        end
    end

    // the read samples the row before any write on the same edge lands
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rd_data <= mem[rd_req.addr];
            tag_idx <= rd_req.req_idx;
            tag_opd <= rd_req.opd_id;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_valid;
        end
    end

    always_comb begin
        rsp.req_idx = tag_idx;
        rsp.opd_id = tag_opd;
        rsp.data = rd_data;
    end

endmodule

/* src/gpr_defines.svh */
/* size parameters of the banked register file
   included by the packages and the testbench */
`ifndef GPR_DEFINES_SVH
`define GPR_DEFINES_SVH

// operand collectors reading the register file
`define GPR_NUM_REQS 4

// must be a power of two no larger than GPR_NUM_REGS
`define GPR_NUM_BANKS 4

`define GPR_NUM_WARPS 8
`define GPR_NUM_REGS 32

// threads per warp and the width of one thread's word
`define GPR_LANES 4
`define GPR_XLEN 32

// width of the bank collision stall counter
`define GPR_PERF_W 16

`endif

/* src/gpr_msg_pkg.sv */
/* packed messages passed between the register file blocks and across its ports
   field types come from the width package */
`include "gpr_defines.svh"

package gpr_msg_pkg;

    // read request from an operand collector
    typedef struct packed {
        gpr_types_pkg::opd_id_t opd_id;
        gpr_types_pkg::warp_id_t wid;
        gpr_types_pkg::reg_id_t reg_id;
    } gpr_req_t;

    // read response back to the collector
    typedef struct packed {
        gpr_types_pkg::opd_id_t opd_id;
        gpr_types_pkg::lane_data_t data;
    } gpr_rsp_t;

    // writeback of a whole or partial warp
    typedef struct packed {
        gpr_types_pkg::warp_id_t wid;
        gpr_types_pkg::reg_id_t rd;
        gpr_types_pkg::lane_mask_t tmask;
        gpr_types_pkg::lane_data_t data;
    } gpr_wb_t;

    // read routed to a bank, still tagged with the requester that issued it
    typedef struct packed {
        gpr_types_pkg::req_idx_t req_idx;
        gpr_types_pkg::opd_id_t opd_id;
        gpr_types_pkg::bank_addr_t addr;
    } bank_req_t;

    typedef struct packed {
        gpr_types_pkg::req_idx_t req_idx;
        gpr_types_pkg::opd_id_t opd_id;
        gpr_types_pkg::lane_data_t data;
    } bank_rsp_t;

endpackage

/* src/gpr_req_xbar.sv */
`timescale 1ns/100ps

/* crossbar from operand requesters to register banks with fixed priority per bank
   the winning request of each bank is registered and counted losers feed the stall counter */
module gpr_req_xbar #(
    parameter int NUM_INPUTS = 4,
    parameter int NUM_OUTPUTS = 4
) (
    input logic clk,
    input logic reset,

    input logic [NUM_INPUTS-1:0] valid_in,
    input gpr_msg_pkg::bank_req_t [NUM_INPUTS-1:0] data_in,
    input gpr_types_pkg::bank_idx_t [NUM_INPUTS-1:0] sel_in,
    output logic [NUM_INPUTS-1:0] ready_in,

    output logic [NUM_OUTPUTS-1:0] valid_out,
    output gpr_msg_pkg::bank_req_t [NUM_OUTPUTS-1:0] data_out,

    output logic [$bits(gpr_types_pkg::req_idx_t):0] collisions
);

    logic [NUM_OUTPUTS-1:0][NUM_INPUTS-1:0] grant;
    logic [NUM_OUTPUTS-1:0] granted;
    gpr_msg_pkg::bank_req_t [NUM_OUTPUTS-1:0] pick;

    for (genvar o = 0; o < NUM_OUTPUTS; o++) begin : g_arb
        logic [NUM_INPUTS-1:0] hit;

        for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_hit
            assign hit[i] = valid_in[i] && (sel_in[i] == gpr_types_pkg::bank_idx_t'(o));
        end

        // keep only the lowest set bit so the lowest requester index wins
        assign grant[o] = hit & ~(hit - 1'b1);
        assign granted[o] = |hit;
    end

    // grants are one-hot per bank, so each bank picks at most one request
    always_comb begin
        ready_in = '0;
        pick = '0;
        for (int o = 0; o < NUM_OUTPUTS; o++) begin
            for (int i = 0; i < NUM_INPUTS; i++) begin
                if (grant[o][i]) begin
                    ready_in[i] = 1'b1;
                    pick[o] = data_in[i];
                end
            end
        end
    end

    always_comb begin
        collisions = '0;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            if (valid_in[i] && !ready_in[i]) begin
                collisions = collisions + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= '0;
        end else begin
            valid_out <= granted;
        end
    end

    // banks never stall so the request register loads every cycle
    always_ff @(posedge clk) begin
        data_out <= pick;
    end

endmodule

/* src/gpr_rsp_route.sv */
`timescale 1ns/100ps

/* returns tagged bank read data to the requester named in each tag
   purely combinational with no back-pressure toward the banks */
module gpr_rsp_route #(
    parameter int NUM_BANKS = 4,
    parameter int NUM_REQS = 4
) (
    input logic [NUM_BANKS-1:0] bank_valid,
    input gpr_msg_pkg::bank_rsp_t [NUM_BANKS-1:0] bank_rsp,

    output logic [NUM_REQS-1:0] rsp_valid,
    output gpr_msg_pkg::gpr_rsp_t [NUM_REQS-1:0] rsp
);

    // a requester is granted at most once per cycle so no two banks name it together
    always_comb begin
        rsp_valid = '0;
        rsp = '0;
        for (int r = 0; r < NUM_REQS; r++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (bank_valid[b] &&
                    (bank_rsp[b].req_idx == gpr_types_pkg::req_idx_t'(r))) begin
                    rsp_valid[r] = 1'b1;
                    rsp[r].opd_id = bank_rsp[b].opd_id;
                    rsp[r].data = bank_rsp[b].data;
                end
            end
        end
    end

endmodule

/* src/gpr_types_pkg.sv */
/* width types shared by the register file blocks and its testbench
   sizes follow the defines header */
`include "gpr_defines.svh"

package gpr_types_pkg;

    localparam int WARP_W = $clog2(`GPR_NUM_WARPS);
    localparam int REG_W = $clog2(`GPR_NUM_REGS);
    localparam int BANK_SEL_BITS = $clog2(`GPR_NUM_BANKS);

    // index widths never drop to zero, even with a single requester or bank
    localparam int REQ_IDX_W = (`GPR_NUM_REQS > 1) ? $clog2(`GPR_NUM_REQS) : 1;
    localparam int BANK_IDX_W = (BANK_SEL_BITS > 0) ? BANK_SEL_BITS : 1;

    typedef logic [WARP_W-1:0] warp_id_t;
    typedef logic [REG_W-1:0] reg_id_t;
    typedef logic [1:0] opd_id_t;

    typedef logic [`GPR_LANES-1:0] lane_mask_t;
    typedef logic [`GPR_LANES*`GPR_XLEN-1:0] lane_data_t;

    typedef logic [REQ_IDX_W-1:0] req_idx_t;
    typedef logic [BANK_IDX_W-1:0] bank_idx_t;

    // warp number on top of the register bits left over after bank select
    typedef logic [WARP_W+REG_W-BANK_SEL_BITS-1:0] bank_addr_t;

    typedef logic [`GPR_PERF_W-1:0] perf_cnt_t;

endpackage

/* src/gpr_unit.sv */
`timescale 1ns/100ps
`include "gpr_defines.svh"

/* general-purpose register file of one issue slice
   collectors read through a banked request crossbar while one writeback port writes warps */
module gpr_unit (
    input logic clk,
    input logic reset,

    input logic [`GPR_NUM_REQS-1:0] req_valid,
    input gpr_msg_pkg::gpr_req_t [`GPR_NUM_REQS-1:0] req,
    output logic [`GPR_NUM_REQS-1:0] req_ready,

    input logic wb_valid,
    input gpr_msg_pkg::gpr_wb_t wb,

    output logic [`GPR_NUM_REQS-1:0] rsp_valid,
    output gpr_msg_pkg::gpr_rsp_t [`GPR_NUM_REQS-1:0] rsp,

    output gpr_types_pkg::perf_cnt_t perf_stalls
);

    localparam int NUM_REQS = `GPR_NUM_REQS;
    localparam int NUM_BANKS = `GPR_NUM_BANKS;
    localparam int REG_W = gpr_types_pkg::REG_W;
    localparam int BANK_SEL_BITS = gpr_types_pkg::BANK_SEL_BITS;

    gpr_msg_pkg::bank_req_t [NUM_REQS-1:0] xbar_req;
    gpr_types_pkg::bank_idx_t [NUM_REQS-1:0] xbar_sel;
    logic [$bits(gpr_types_pkg::req_idx_t):0] collisions;

    logic [NUM_BANKS-1:0] bank_req_valid;
    gpr_msg_pkg::bank_req_t [NUM_BANKS-1:0] bank_req;
    logic [NUM_BANKS-1:0] bank_rsp_valid;
    gpr_msg_pkg::bank_rsp_t [NUM_BANKS-1:0] bank_rsp;

    logic wb_reg_valid;
    gpr_msg_pkg::gpr_wb_t wb_reg;
    gpr_types_pkg::bank_addr_t wb_row;
    gpr_types_pkg::bank_idx_t wb_bank;

    // the row drops the low register bits, which already picked the bank
    function automatic gpr_types_pkg::bank_addr_t row_of(
        gpr_types_pkg::warp_id_t wid,
        gpr_types_pkg::reg_id_t r
    );
        return {wid, r[REG_W-1:BANK_SEL_BITS]};
    endfunction

    function automatic gpr_types_pkg::bank_idx_t bank_of(gpr_types_pkg::reg_id_t r);
        return gpr_types_pkg::bank_idx_t'(r % NUM_BANKS);
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_REQS; i++) begin
            xbar_req[i].req_idx = gpr_types_pkg::req_idx_t'(i);
            xbar_req[i].opd_id = req[i].opd_id;
            xbar_req[i].addr = row_of(req[i].wid, req[i].reg_id);
            xbar_sel[i] = bank_of(req[i].reg_id);
        end
    end

    gpr_req_xbar #(
        .NUM_INPUTS  (NUM_REQS),
        .NUM_OUTPUTS (NUM_BANKS)
    ) req_xbar (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (req_valid),
        .data_in    (xbar_req),
        .sel_in     (xbar_sel),
        .ready_in   (req_ready),
        .valid_out  (bank_req_valid),
        .data_out   (bank_req),
        .collisions (collisions)
    );

    // the writeback reaches the RAM one edge late, together with the RAM read of
    // requests that transferred on its edge, so those reads still return the old row
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_reg_valid <= 1'b0;
        end else begin
            wb_reg_valid <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg <= wb;
    end

    assign wb_row = row_of(wb_reg.wid, wb_reg.rd);
    assign wb_bank = bank_of(wb_reg.rd);

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_banks
        gpr_bank bank (
            .clk       (clk),
            .reset     (reset),
            .rd_valid  (bank_req_valid[b]),
            .rd_req    (bank_req[b]),
            .wr_en     (wb_reg_valid && (wb_bank == gpr_types_pkg::bank_idx_t'(b))),
            .wr_addr   (wb_row),
            .wr_mask   (wb_reg.tmask),
            .wr_data   (wb_reg.data),
            .rsp_valid (bank_rsp_valid[b]),
            .rsp       (bank_rsp[b])
        );
    end

    gpr_rsp_route #(
        .NUM_BANKS (NUM_BANKS),
        .NUM_REQS  (NUM_REQS)
    ) rsp_route (
        .bank_valid (bank_rsp_valid),
        .bank_rsp   (bank_rsp),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_stalls <= '0;
        end else begin
            perf_stalls <= perf_stalls + gpr_types_pkg::perf_cnt_t'(collisions);
        end
    end

endmodule

/* test/gpr_unit_tb.sv */
`timescale 1ns/100ps
`include "gpr_defines.svh"

/* self-checking testbench for the banked register file against a shadow register model
   directed fills, partial writes, collisions and random traffic are checked by assertions */
module gpr_unit_tb;

    localparam int NUM_REQS = `GPR_NUM_REQS;
    localparam int NUM_BANKS = `GPR_NUM_BANKS;
    localparam int NUM_WARPS = `GPR_NUM_WARPS;
    localparam int NUM_REGS = `GPR_NUM_REGS;
    localparam int LANES = `GPR_LANES;
    localparam int XLEN = `GPR_XLEN;
    localparam int CLK_PERIOD = 20;
    localparam int PARTIAL_WRITES = 32;
    localparam int RAND_CYCLES = 400;
    localparam int PEND_DEPTH = 128;
    localparam int EXP_DEPTH = 8;
    localparam int TEST_CYCLES = 3 * NUM_WARPS * NUM_REGS + 3 * RAND_CYCLES + 200;

    logic clk;
    logic reset;
    logic [NUM_REQS-1:0] req_valid;
    gpr_msg_pkg::gpr_req_t [NUM_REQS-1:0] req;
    logic [NUM_REQS-1:0] req_ready;
    logic wb_valid;
    gpr_msg_pkg::gpr_wb_t wb;
    logic [NUM_REQS-1:0] rsp_valid;
    gpr_msg_pkg::gpr_rsp_t [NUM_REQS-1:0] rsp;
    gpr_types_pkg::perf_cnt_t perf_stalls;

    logic [31:0] rng_state = 32'hfba9_961c;
    int errors = 0;
    int rsp_checked = 0;
    int stall_cnt = 0;
    int cyc = 0;
    logic [NUM_REQS-1:0] xfer = '0;

    gpr_types_pkg::lane_data_t shadow [NUM_WARPS][NUM_REGS];

    // reads waiting to be presented, one ring per requester
    gpr_msg_pkg::gpr_req_t pend_req [NUM_REQS][PEND_DEPTH];
    int pend_head [NUM_REQS];
    int pend_tail [NUM_REQS];
    gpr_msg_pkg::gpr_wb_t wb_q [$];

    // responses owed to each requester in handshake order
    gpr_types_pkg::opd_id_t exp_opd [NUM_REQS][EXP_DEPTH];
    gpr_types_pkg::lane_data_t exp_data [NUM_REQS][EXP_DEPTH];
    int exp_due [NUM_REQS][EXP_DEPTH];
    int exp_head [NUM_REQS];
    int exp_tail [NUM_REQS];

    gpr_unit DUT (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .perf_stalls (perf_stalls)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic gpr_types_pkg::lane_data_t rand_data();
        gpr_types_pkg::lane_data_t d;
        for (int l = 0; l < LANES; l++) begin
            d[l*XLEN +: XLEN] = XLEN'(next_rand());
        end
        return d;
    endfunction

    function automatic gpr_msg_pkg::gpr_wb_t make_wb(int w, int rn,
                                                    gpr_types_pkg::lane_mask_t m,
                                                    gpr_types_pkg::lane_data_t d);
        gpr_msg_pkg::gpr_wb_t x;
        x.wid = gpr_types_pkg::warp_id_t'(w);
        x.rd = gpr_types_pkg::reg_id_t'(rn);
        x.tmask = m;
        x.data = d;
        return x;
    endfunction

    // bank selection follows the low bits of the register number
    function automatic int expected_bank(gpr_types_pkg::reg_id_t rn);
        return int'(rn) % NUM_BANKS;
    endfunction

    function automatic logic traffic_pending();
        logic b;
        b = wb_valid || (wb_q.size() > 0) || (|req_valid);
        for (int r = 0; r < NUM_REQS; r++) begin
            if (pend_head[r] != pend_tail[r] || exp_head[r] != exp_tail[r]) begin
                b = 1'b1;
            end
        end
        return b;
    endfunction

    task automatic push_read(int r, int w, int rn, logic [31:0] opd);
        gpr_msg_pkg::gpr_req_t x;
        x.opd_id = gpr_types_pkg::opd_id_t'(opd);
        x.wid = gpr_types_pkg::warp_id_t'(w);
        x.reg_id = gpr_types_pkg::reg_id_t'(rn);
        pend_req[r][pend_tail[r] % PEND_DEPTH] = x;
        pend_tail[r]++;
    endtask

    // one clock of stimulus, a held request stays until its handshake
    task automatic step();
        @(posedge clk);
        #2;
        for (int r = 0; r < NUM_REQS; r++) begin
            if (xfer[r]) begin
                req_valid[r] = 1'b0;
            end
            if (!req_valid[r] && pend_head[r] != pend_tail[r]) begin
                req[r] = pend_req[r][pend_head[r] % PEND_DEPTH];
                req_valid[r] = 1'b1;
                pend_head[r]++;
            end
        end
        if (wb_q.size() > 0) begin
            wb = wb_q.pop_front();
            wb_valid = 1'b1;
        end else begin
            wb_valid = 1'b0;
        end
    endtask

    task automatic run_until_idle();
        while (traffic_pending()) begin
            step();
        end
    endtask

    always @(posedge clk) begin
        int slot;
        logic due_now;
        logic exp_ready;
        if (reset) begin
            xfer = '0;
        end else begin
            cyc++;
            for (int r = 0; r < NUM_REQS; r++) begin
                slot = exp_head[r] % EXP_DEPTH;
                due_now = (exp_head[r] != exp_tail[r]) && (exp_due[r][slot] == cyc);
                assert (rsp_valid[r] == due_now) else begin
                    errors++;
                    $display("[ERROR] rsp_valid[%0d]: got %h expected %h at cycle %0d",
                             r, rsp_valid[r], due_now, cyc);
                end
                if (rsp_valid[r] && due_now) begin
                    rsp_checked++;
                    assert (rsp[r].opd_id == exp_opd[r][slot]) else begin
                        errors++;
                        $display("[ERROR] rsp[%0d].opd_id: got %h expected %h",
                                 r, rsp[r].opd_id, exp_opd[r][slot]);
                    end
                    assert (rsp[r].data == exp_data[r][slot]) else begin
                        errors++;
                        $display("[ERROR] rsp[%0d].data: got %h expected %h",
                                 r, rsp[r].data, exp_data[r][slot]);
                    end
                end
                if (due_now) begin
                    exp_head[r]++;
                end
            end
            // the lowest valid requester of each bank is the only one granted
            for (int i = 0; i < NUM_REQS; i++) begin
                exp_ready = req_valid[i];
                for (int j = 0; j < i; j++) begin
                    if (req_valid[j] &&
                        expected_bank(req[j].reg_id) == expected_bank(req[i].reg_id)) begin
                        exp_ready = 1'b0;
                    end
                end
                assert (req_ready[i] == exp_ready) else begin
                    errors++;
                    $display("[ERROR] req_ready[%0d]: got %h expected %h",
                             i, req_ready[i], exp_ready);
                end
                if (req_valid[i] && !exp_ready) begin
                    stall_cnt++;
                end
            end
            // reads that transfer on this edge see the rows before this edge's writeback
            for (int r = 0; r < NUM_REQS; r++) begin
                if (req_valid[r] && req_ready[r]) begin
                    slot = exp_tail[r] % EXP_DEPTH;
                    exp_opd[r][slot] = req[r].opd_id;
                    exp_data[r][slot] = shadow[req[r].wid][req[r].reg_id];
                    exp_due[r][slot] = cyc + 2;
                    exp_tail[r]++;
                end
            end
            if (wb_valid) begin
                for (int l = 0; l < LANES; l++) begin
                    if (wb.tmask[l]) begin
                        shadow[wb.wid][wb.rd][l*XLEN +: XLEN] = wb.data[l*XLEN +: XLEN];
                    end
                end
            end
            xfer = req_valid & req_ready;
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 1000);
        $display("watchdog expired before the stimulus finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        int pw [PARTIAL_WRITES];
        int pg [PARTIAL_WRITES];
        logic [31:0] rnd;
        clk = 1'b0;
        reset = 1'b1;
        req_valid = '0;
        req = '0;
        wb_valid = 1'b0;
        wb = '0;
        for (int r = 0; r < NUM_REQS; r++) begin
            pend_head[r] = 0;
            pend_tail[r] = 0;
            exp_head[r] = 0;
            exp_tail[r] = 0;
        end
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (rsp_valid == '0) else begin
            errors++;
            $display("[ERROR] rsp_valid: got %h expected %h after reset", rsp_valid, 0);
        end
        assert (perf_stalls == '0) else begin
            errors++;
            $display("[ERROR] perf_stalls: got %h expected %h after reset", perf_stalls, 0);
        end

        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int rn = 0; rn < NUM_REGS; rn++) begin
                wb_q.push_back(make_wb(w, rn, '1, rand_data()));
            end
        end
        run_until_idle();
        for (int i = 0; i < NUM_WARPS * NUM_REGS; i++) begin
            push_read(i % NUM_REQS, i / NUM_REGS, i % NUM_REGS, next_rand());
        end
        run_until_idle();

        for (int i = 0; i < PARTIAL_WRITES; i++) begin
            pw[i] = int'(next_rand() % NUM_WARPS);
            pg[i] = int'(next_rand() % NUM_REGS);
            wb_q.push_back(make_wb(pw[i], pg[i], gpr_types_pkg::lane_mask_t'(next_rand()),
                                   rand_data()));
        end
        run_until_idle();
        for (int i = 0; i < PARTIAL_WRITES; i++) begin
            push_read(i % NUM_REQS, pw[i], pg[i], next_rand());
        end
        run_until_idle();

        // the first read and the writeback share one edge, the second read follows it
        push_read(0, 3, 5, 1);
        wb_q.push_back(make_wb(3, 5, '1, rand_data()));
        step();
        push_read(1, 3, 5, 2);
        run_until_idle();

        // every requester on bank 0, then one requester per bank
        for (int r = 0; r < NUM_REQS; r++) begin
            push_read(r, r, 4 * (r + 1), r);
        end
        run_until_idle();
        for (int r = 0; r < NUM_REQS; r++) begin
            push_read(r, 1, r, r);
        end
        run_until_idle();

        repeat (RAND_CYCLES) begin
            for (int r = 0; r < NUM_REQS; r++) begin
                rnd = next_rand();
                if (pend_head[r] == pend_tail[r] && rnd[0]) begin
                    push_read(r, int'(rnd[10:8]) % NUM_WARPS, int'(rnd[20:16]) % NUM_REGS,
                              rnd[31:30]);
                end
            end
            rnd = next_rand();
            if (wb_q.size() == 0 && rnd[1]) begin
                wb_q.push_back(make_wb(int'(rnd[10:8]) % NUM_WARPS, int'(rnd[20:16]) % NUM_REGS,
                                       gpr_types_pkg::lane_mask_t'(rnd >> 24), rand_data()));
            end
            step();
        end
        run_until_idle();
        assert (perf_stalls == gpr_types_pkg::perf_cnt_t'(stall_cnt)) else begin
            errors++;
            $display("[ERROR] perf_stalls: got %h expected %h", perf_stalls, stall_cnt);
        end

        $display("errors %0d, responses checked %0d, stalls counted %0d",
                 errors, rsp_checked, stall_cnt);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
